// File: fdiv_config.svh
// Format and sizing constants for the single-precision divider
// Shared by the package, the RTL blocks and the testbench
`ifndef FDIV_CONFIG_SVH
`define FDIV_CONFIG_SVH

// IEEE 754 binary32 layout
`define FDIV_WIDTH        32
`define FDIV_EXP_BITS     8
`define FDIV_FRAC_BITS    23

// Significand with the hidden bit
`define FDIV_MANT_BITS    24

// Signed working exponent, wide enough for difference plus bias
`define FDIV_EXP_EXT_BITS 10
`define FDIV_BIAS         127

// Quotient register: integer bit plus 25 fraction bits
`define FDIV_QUOT_BITS    26

// One setup compare plus 25 shift/subtract steps
`define FDIV_DIV_CYCLES   26
`define FDIV_CNT_BITS     5

`endif

// File: fdiv_pkg.sv
// Divider types: FSM states, exception flags and the structs passed
// between unpack, significand divider and rounder

`include "fdiv_config.svh"

package fdiv_pkg;

  // ====================================================================
  // Operation FSM
  // ====================================================================

  typedef enum logic [2:0] {
    IDLE,
    UNPACK,
    DIVIDE,
    ROUND,
    DONE
  } fdiv_state_e;

  // ====================================================================
  // Exception flags and datapath structs
  // ====================================================================

  // Standard IEEE flags, invalid in the MSB
  typedef struct packed {
    logic invalid;
    logic div_zero;
    logic overflow;
    logic underflow;
    logic inexact;
  } fp_flags_t;

  // Early-out result for NaN, inf and zero operands
  typedef struct packed {
    logic                    is_special;
    logic [`FDIV_WIDTH-1:0]  result;
    fp_flags_t               flags;
  } fdiv_special_t;

  // Normal operand pair after unpack
  typedef struct packed {
    logic                                 sign;
    logic signed [`FDIV_EXP_EXT_BITS-1:0] exp;
    logic        [`FDIV_MANT_BITS-1:0]    dividend;
    logic        [`FDIV_MANT_BITS-1:0]    divisor;
  } fdiv_operands_t;

  // Raw quotient plus remainder-nonzero
  typedef struct packed {
    logic [`FDIV_QUOT_BITS-1:0] quot;
    logic                       sticky;
  } fdiv_quot_t;

endpackage

// File: fdiv_unpack.sv
// Operand unpack: field split, NaN/inf/zero classification, special-case
// result selection and biased exponent difference for normal pairs
`timescale 1ns/10ps
`include "fdiv_config.svh"

module fdiv_unpack (
  input  logic [`FDIV_WIDTH-1:0]    i_operand_a,
  input  logic [`FDIV_WIDTH-1:0]    i_operand_b,
  output fdiv_pkg::fdiv_operands_t  o_ops,
  output fdiv_pkg::fdiv_special_t   o_special
);

  localparam int EXT_PAD = `FDIV_EXP_EXT_BITS - `FDIV_EXP_BITS;
  localparam logic [`FDIV_EXP_BITS-1:0] EXP_ONES = '1;
  localparam logic [`FDIV_WIDTH-1:0] CANON_NAN =
    {1'b0, EXP_ONES, 1'b1, {(`FDIV_FRAC_BITS - 1){1'b0}}};
  localparam logic signed [`FDIV_EXP_EXT_BITS-1:0] BIAS_EXT = `FDIV_BIAS;

  logic                       sign_a, sign_b, sign_r;
  logic [`FDIV_EXP_BITS-1:0]  exp_a, exp_b;
  logic [`FDIV_FRAC_BITS-1:0] frac_a, frac_b;
  logic                       zero_a, zero_b, inf_a, inf_b;
  logic                       nan_a, nan_b, snan_a, snan_b;

  assign {sign_a, exp_a, frac_a} = i_operand_a;
  assign {sign_b, exp_b, frac_b} = i_operand_b;
  assign sign_r = sign_a ^ sign_b;

  // Subnormals count as zero (DAZ)
  assign zero_a = (exp_a == '0);
  assign zero_b = (exp_b == '0);
  assign inf_a  = (exp_a == EXP_ONES) && (frac_a == '0);
  assign inf_b  = (exp_b == EXP_ONES) && (frac_b == '0);
  assign nan_a  = (exp_a == EXP_ONES) && (frac_a != '0);
  assign nan_b  = (exp_b == EXP_ONES) && (frac_b != '0);
  // Quiet bit clear marks a signaling NaN
  assign snan_a = nan_a && !frac_a[`FDIV_FRAC_BITS-1];
  assign snan_b = nan_b && !frac_b[`FDIV_FRAC_BITS-1];

  // Special cases, first match wins
  always_comb begin
    o_special = '0;
    o_special.is_special = nan_a || nan_b || inf_a || inf_b || zero_a || zero_b;
    if (nan_a || nan_b) begin
      o_special.result = CANON_NAN;
      o_special.flags.invalid = snan_a | snan_b;
    end else if ((inf_a && inf_b) || (zero_a && zero_b)) begin
      // inf/inf and 0/0 have no meaningful value
      o_special.result = CANON_NAN;
      o_special.flags.invalid = 1'b1;
    end else if (inf_a) begin
      o_special.result = {sign_r, EXP_ONES, {`FDIV_FRAC_BITS{1'b0}}};
    end else if (inf_b) begin
      o_special.result = {sign_r, {(`FDIV_WIDTH - 1){1'b0}}};
    end else if (zero_b) begin
      // Finite nonzero over zero
      o_special.result = {sign_r, EXP_ONES, {`FDIV_FRAC_BITS{1'b0}}};
      o_special.flags.div_zero = 1'b1;
    end else if (zero_a) begin
      o_special.result = {sign_r, {(`FDIV_WIDTH - 1){1'b0}}};
    end
  end

  // Normal pair: hidden-bit significands, ea - eb + bias
  always_comb begin
    o_ops.sign     = sign_r;
    o_ops.exp      = $signed({{EXT_PAD{1'b0}}, exp_a}) -
                     $signed({{EXT_PAD{1'b0}}, exp_b}) + BIAS_EXT;
    o_ops.dividend = {1'b1, frac_a};
    o_ops.divisor  = {1'b1, frac_b};
  end

endmodule

// File: fdiv_mant_div.sv
// Radix-2 restoring divider for 24-bit significands, one quotient bit
// per cycle, integer bit resolved on the start cycle
`timescale 1ns/10ps
`include "fdiv_config.svh"

module fdiv_mant_div (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  logic                        i_start,
  input  logic [`FDIV_MANT_BITS-1:0]  i_dividend,
  input  logic [`FDIV_MANT_BITS-1:0]  i_divisor,
  output fdiv_pkg::fdiv_quot_t        o_quot,
  output logic                        o_done
);

  localparam logic [`FDIV_CNT_BITS-1:0] LAST_CNT = `FDIV_CNT_BITS'(`FDIV_DIV_CYCLES - 1);

  logic [`FDIV_QUOT_BITS-1:0] quot_q;
  logic [`FDIV_MANT_BITS-1:0] rem_q;
  logic [`FDIV_MANT_BITS-1:0] divisor_q;
  logic [`FDIV_CNT_BITS-1:0]  cnt_q;
  logic                       running_q;
  // Doubled remainder needs one extra bit
  logic [`FDIV_MANT_BITS:0]   rem_shl;
  logic [`FDIV_MANT_BITS:0]   rem_sub;
  logic                       bit_set;

  always_comb begin
    rem_shl = {rem_q, 1'b0};
    rem_sub = rem_shl - {1'b0, divisor_q};
    bit_set = (rem_shl >= {1'b0, divisor_q});
  end

  // Last step happens on the edge that ends the done cycle
  assign o_done = running_q && (cnt_q == LAST_CNT);
  assign o_quot = '{quot: quot_q, sticky: |rem_q};

  // cnt_q counts quotient bits produced so far
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      running_q <= 1'b0;
      cnt_q     <= '0;
    end else if (i_start) begin
      running_q <= 1'b1;
      cnt_q     <= `FDIV_CNT_BITS'(1);
    end else if (running_q) begin
      cnt_q <= cnt_q + 1'b1;
      if (o_done) begin
        running_q <= 1'b0;
      end
    end
  end

  // Remainder always stays below the divisor, so 24 bits hold it
  always_ff @(posedge i_clk) begin
    if (i_start) begin
      divisor_q <= i_divisor;
      if (i_dividend >= i_divisor) begin
        quot_q <= `FDIV_QUOT_BITS'(1);
        rem_q  <= i_dividend - i_divisor;
      end else begin
        quot_q <= '0;
        rem_q  <= i_dividend;
      end
    end else if (running_q) begin
      quot_q <= {quot_q[`FDIV_QUOT_BITS-2:0], bit_set};
      rem_q  <= bit_set ? rem_sub[`FDIV_MANT_BITS-1:0] : rem_shl[`FDIV_MANT_BITS-1:0];
    end
  end

  // Done arrives a fixed number of cycles after its start
  assert property (@(posedge i_clk) disable iff (i_rst)
    o_done |-> $past(i_start, `FDIV_DIV_CYCLES - 1))
    else $error("mant_div: done without matching start");

endmodule

// File: fdiv_round.sv
// Quotient normalize and round to nearest even, with overflow to inf
// and flush of tiny results to zero
`timescale 1ns/10ps
`include "fdiv_config.svh"

module fdiv_round (
  input  fdiv_pkg::fdiv_quot_t                 i_quot,
  input  logic                                 i_sign,
  input  logic signed [`FDIV_EXP_EXT_BITS-1:0] i_exp,
  output logic        [`FDIV_WIDTH-1:0]        o_result,
  output fdiv_pkg::fp_flags_t                  o_flags
);

  localparam int QB = `FDIV_QUOT_BITS;
  localparam int MB = `FDIV_MANT_BITS;
  localparam logic signed [`FDIV_EXP_EXT_BITS-1:0] EXP_ONE = 1;
  localparam logic signed [`FDIV_EXP_EXT_BITS-1:0] EXP_ZERO = 0;
  localparam logic signed [`FDIV_EXP_EXT_BITS-1:0] EXP_INF = 255;
  localparam logic [`FDIV_EXP_BITS-1:0] EXP_ONES = '1;

  logic                                 lead;
  logic        [QB-1:0]                 q_norm;
  logic signed [`FDIV_EXP_EXT_BITS-1:0] exp_norm;
  logic signed [`FDIV_EXP_EXT_BITS-1:0] exp_rnd;
  logic        [MB-1:0]                 sig;
  logic                                 guard;
  logic                                 sticky;
  logic                                 round_up;
  logic        [MB:0]                   sig_rnd;
  logic        [`FDIV_FRAC_BITS-1:0]    frac_out;

  always_comb begin
    // Quotient lies in (0.5, 2) and needs at most one left shift
    lead     = i_quot.quot[QB-1];
    q_norm   = lead ? i_quot.quot : {i_quot.quot[QB-2:0], 1'b0};
    exp_norm = lead ? i_exp : i_exp - EXP_ONE;

    // Keep 24 bits and one guard bit and fold the rest into sticky
    sig    = q_norm[QB-1 -: MB];
    guard  = q_norm[1];
    sticky = q_norm[0] | i_quot.sticky;

    // Nearest even rounds up above half, or at half with an odd LSB
    round_up = guard & (sticky | sig[0]);
    sig_rnd  = {1'b0, sig} + (MB + 1)'(round_up);

    // Carry out means 1.111..1 became 10.000..0
    if (sig_rnd[MB]) begin
      exp_rnd  = exp_norm + EXP_ONE;
      frac_out = sig_rnd[MB-1:1];
    end else begin
      exp_rnd  = exp_norm;
      frac_out = sig_rnd[MB-2:0];
    end

    o_flags = '0;
    o_flags.inexact = guard | sticky;
    if (exp_rnd >= EXP_INF) begin
      o_result = {i_sign, EXP_ONES, {`FDIV_FRAC_BITS{1'b0}}};
      o_flags.overflow = 1'b1;
      o_flags.inexact  = 1'b1;
    end else if (exp_rnd <= EXP_ZERO) begin
      // No subnormal output so tiny results flush to signed zero
      o_result = {i_sign, {(`FDIV_WIDTH - 1){1'b0}}};
      o_flags.underflow = 1'b1;
      o_flags.inexact   = 1'b1;
    end else begin
      o_result = {i_sign, exp_rnd[`FDIV_EXP_BITS-1:0], frac_out};
    end
  end

endmodule

// File: fp_divider.sv
// Sequential IEEE 754 single-precision divider, round to nearest even
// Valid pulse in, valid pulse out, busy while an operation is in flight
`timescale 1ns/10ps
`include "fdiv_config.svh"

module fp_divider (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic                     i_valid,
  input  logic [`FDIV_WIDTH-1:0]   i_operand_a,
  input  logic [`FDIV_WIDTH-1:0]   i_operand_b,
  output logic [`FDIV_WIDTH-1:0]   o_result,
  output fdiv_pkg::fp_flags_t      o_flags,
  output logic                     o_valid,
  output logic                     o_busy
);

  import fdiv_pkg::*;

  fdiv_state_e            state_q, state_d;
  logic [`FDIV_WIDTH-1:0] op_a_q, op_b_q;
  fdiv_operands_t         unpack_ops, ops_q;
  fdiv_special_t          unpack_special;
  fdiv_quot_t             quot;
  logic                   div_start_q;
  logic                   div_done;
  logic [`FDIV_WIDTH-1:0] round_result;
  fp_flags_t              round_flags;
  logic [`FDIV_WIDTH-1:0] result_q;
  fp_flags_t              flags_q;
  logic                   valid_q;

  // ====================================================================
  // Datapath blocks
  // ====================================================================

  fdiv_unpack unpack_i (
    .i_operand_a (op_a_q),
    .i_operand_b (op_b_q),
    .o_ops       (unpack_ops),
    .o_special   (unpack_special)
  );

  fdiv_mant_div mant_div_i (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_start    (div_start_q),
    .i_dividend (ops_q.dividend),
    .i_divisor  (ops_q.divisor),
    .o_quot     (quot),
    .o_done     (div_done)
  );

  fdiv_round round_i (
    .i_quot   (quot),
    .i_sign   (ops_q.sign),
    .i_exp    (ops_q.exp),
    .o_result (round_result),
    .o_flags  (round_flags)
  );

  // ====================================================================
  // Operation FSM
  // ====================================================================

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (i_valid) state_d = UNPACK;
      // Specials skip the divider entirely
      UNPACK:  state_d = unpack_special.is_special ? DONE : DIVIDE;
      DIVIDE:  if (div_done) state_d = ROUND;
      ROUND:   state_d = DONE;
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q     <= IDLE;
      div_start_q <= 1'b0;
      valid_q     <= 1'b0;
      result_q    <= '0;
      flags_q     <= '0;
    end else begin
      state_q     <= state_d;
      div_start_q <= 1'b0;
      valid_q     <= 1'b0;
      case (state_q)
        UNPACK: begin
          if (unpack_special.is_special) begin
            result_q <= unpack_special.result;
            flags_q  <= unpack_special.flags;
          end else begin
            // Start pulse lands in the first DIVIDE cycle
            div_start_q <= 1'b1;
          end
        end
        ROUND: begin
          result_q <= round_result;
          flags_q  <= round_flags;
        end
        DONE:    valid_q <= 1'b1;
        default: ;
      endcase
    end
  end

  // Operand capture and unpack registers
  always_ff @(posedge i_clk) begin
    if (state_q == IDLE && i_valid) begin
      op_a_q <= i_operand_a;
      op_b_q <= i_operand_b;
    end
    if (state_q == UNPACK) begin
      ops_q <= unpack_ops;
    end
  end

  assign o_result = result_q;
  assign o_flags  = flags_q;
  assign o_valid  = valid_q;
  // Busy from the accepting cycle until the result is out
  assign o_busy   = ((state_q != IDLE) || i_valid) && !valid_q;

  assert property (@(posedge i_clk) disable iff (i_rst) o_valid |=> !o_valid)
    else $error("fp_divider: o_valid longer than one cycle");

  // Result always closes a busy stretch
  assert property (@(posedge i_clk) disable iff (i_rst) o_valid |-> $past(o_busy))
    else $error("fp_divider: o_valid without preceding busy");

endmodule

// File: tb_fp_divider.sv
// Testbench for the single-precision divider with directed and random operands,
// an IEEE reference model, handshake checks and a watchdog
`timescale 1ns/10ps
`include "fdiv_config.svh"

module tb_fp_divider;

  import fdiv_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int N_RANDOM = 500;
  // 4 exact, random, 10 special, 4 range, 2 subnormal
  localparam int NUM_OPS = 4 + N_RANDOM + 10 + 4 + 2;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 40 + 8 + 20;

  logic                   i_clk, i_rst, i_valid;
  logic [`FDIV_WIDTH-1:0] i_operand_a, i_operand_b;
  logic [`FDIV_WIDTH-1:0] o_result;
  fp_flags_t              o_flags;
  logic                   o_valid, o_busy;

  logic [63:0] op_q[$];
  int          issued, checked, errors, n_tests;
  int          test_err0, test_ops0;
  string       test_name;
  logic        pending, prev_valid;

  fp_divider fp_divider_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_valid     (i_valid),
    .i_operand_a (i_operand_a),
    .i_operand_b (i_operand_b),
    .o_result    (o_result),
    .o_flags     (o_flags),
    .o_valid     (o_valid),
    .o_busy      (o_busy)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // ====================================================================
  // Reference model returning {result, invalid, div_zero, ovf, unf, inexact}
  // ====================================================================

  function automatic logic [36:0] ref_divide(input logic [31:0] a, input logic [31:0] b);
    logic        s, za, zb, ia, ib, na, nb, sna, snb, guard, sticky;
    logic [63:0] num, den, q, r;
    logic [24:0] sig;
    logic [31:0] res;
    logic [4:0]  fl;
    int          exp;
    s   = a[31] ^ b[31];
    // Subnormals count as zero
    za  = (a[30:23] == 8'h00);
    zb  = (b[30:23] == 8'h00);
    ia  = (a[30:23] == 8'hFF) && (a[22:0] == '0);
    ib  = (b[30:23] == 8'hFF) && (b[22:0] == '0);
    na  = (a[30:23] == 8'hFF) && (a[22:0] != '0);
    nb  = (b[30:23] == 8'hFF) && (b[22:0] != '0);
    sna = na && !a[22];
    snb = nb && !b[22];
    fl  = '0;
    res = '0;
    if (na || nb) begin
      res = 32'h7FC00000;
      fl[4] = sna | snb;
    end else if ((ia && ib) || (za && zb)) begin
      res = 32'h7FC00000;
      fl[4] = 1'b1;
    end else if (ia) begin
      res = {s, 8'hFF, 23'h0};
    end else if (ib) begin
      res = {s, 31'h0};
    end else if (zb) begin
      res = {s, 8'hFF, 23'h0};
      fl[3] = 1'b1;
    end else if (za) begin
      res = {s, 31'h0};
    end else begin
      // Long division with 26 extra bits gives 24 bits, guard and more
      num = 64'({1'b1, a[22:0]}) << 26;
      den = 64'({1'b1, b[22:0]});
      q   = num / den;
      r   = num % den;
      exp = int'(a[30:23]) - int'(b[30:23]) + `FDIV_BIAS;
      if (q[26]) begin
        sig    = {1'b0, q[26:3]};
        guard  = q[2];
        sticky = (|q[1:0]) || (r != 0);
      end else begin
        sig    = {1'b0, q[25:2]};
        guard  = q[1];
        sticky = q[0] || (r != 0);
        exp    = exp - 1;
      end
      if (guard && (sticky || sig[0])) sig = sig + 25'd1;
      if (sig[24]) begin
        sig = sig >> 1;
        exp = exp + 1;
      end
      fl[0] = guard | sticky;
      if (exp >= 255) begin
        res = {s, 8'hFF, 23'h0};
        fl  = 5'b00101;
      end else if (exp <= 0) begin
        res = {s, 31'h0};
        fl  = 5'b00011;
      end else begin
        res = {s, exp[7:0], sig[22:0]};
      end
    end
    return {res, fl};
  endfunction

  // ====================================================================
  // Compare and handshake monitor sampling values held through the cycle
  // ====================================================================

  always @(posedge i_clk) begin
    logic [63:0] pair;
    logic [36:0] exp_v;
    if (i_rst) begin
      pending    = 1'b0;
      prev_valid = 1'b0;
    end else begin
      if (o_valid && prev_valid) begin
        $display("Error at %0t: o_valid stayed high for two cycles", $time);
        errors++;
      end
      if (o_valid) begin
        if (!pending) begin
          $display("Error at %0t: o_valid with no operation in flight", $time);
          errors++;
        end
        if (o_busy !== 1'b0) begin
          $display("CHECK FAILED t=%0t o_busy got %b expected 0", $time, o_busy);
          errors++;
        end
        if (op_q.size() == 0) begin
          $display("Error at %0t: result arrived with no operands queued", $time);
          errors++;
        end else begin
          pair  = op_q.pop_front();
          exp_v = ref_divide(pair[63:32], pair[31:0]);
          if (o_result !== exp_v[36:5]) begin
            $display("CHECK FAILED t=%0t o_result got %h expected %h (a=%h b=%h)",
                     $time, o_result, exp_v[36:5], pair[63:32], pair[31:0]);
            errors++;
          end
          if (o_flags !== exp_v[4:0]) begin
            $display("CHECK FAILED t=%0t o_flags got %b expected %b (a=%h b=%h)",
                     $time, o_flags, exp_v[4:0], pair[63:32], pair[31:0]);
            errors++;
          end
        end
        pending = 1'b0;
        checked++;
      end else if (i_valid || pending) begin
        // Busy from the accepting cycle until the result
        if (o_busy !== 1'b1) begin
          $display("CHECK FAILED t=%0t o_busy got %b expected 1", $time, o_busy);
          errors++;
        end
        pending = 1'b1;
      end else if (o_busy !== 1'b0) begin
        $display("CHECK FAILED t=%0t o_busy got %b expected 0", $time, o_busy);
        errors++;
      end
      prev_valid = o_valid;
    end
  end

  // ====================================================================
  // Stimulus
  // ====================================================================

  task automatic issue_op(input logic [31:0] a, input logic [31:0] b);
    @(posedge i_clk);
    i_valid     <= 1'b1;
    i_operand_a <= a;
    i_operand_b <= b;
    op_q.push_back({a, b});
    issued++;
    @(posedge i_clk);
    i_valid <= 1'b0;
    wait (checked == issued);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err0 = errors;
    test_ops0 = issued;
  endtask

  task automatic end_test();
    n_tests++;
    $display("test %s: %0d ops, %0d errors", test_name, issued - test_ops0,
             errors - test_err0);
  endtask

  // Random normal operand with exponent within 20 of the bias
  function automatic logic [31:0] random_normal();
    int e;
    e = 107 + int'($urandom % 32'd41);
    return {1'($urandom), e[7:0], 23'($urandom)};
  endfunction

  initial begin
    void'($urandom(32'ha463));
    i_rst       = 1'b1;
    i_valid     = 1'b0;
    i_operand_a = '0;
    i_operand_b = '0;
    repeat (8) @(posedge i_clk);
    i_rst <= 1'b0;

    // Quiet outputs and cleared result registers before any operation
    begin_test("reset_idle");
    repeat (4) @(posedge i_clk);
    if (o_result !== '0) begin
      $display("CHECK FAILED t=%0t o_result got %h expected %h", $time, o_result, 32'h0);
      errors++;
    end
    if (o_flags !== '0) begin
      $display("CHECK FAILED t=%0t o_flags got %b expected %b", $time, o_flags, 5'b0);
      errors++;
    end
    end_test();

    begin_test("exact_quotients");
    issue_op(32'h40C00000, 32'h40400000);
    issue_op(32'h3F800000, 32'h40800000);
    issue_op(32'hC1100000, 32'h40400000);
    issue_op(32'h3F800000, 32'h3F800000);
    end_test();

    begin_test("random_normals");
    for (int i = 0; i < N_RANDOM; i++) begin
      issue_op(random_normal(), random_normal());
    end
    end_test();

    begin_test("special_cases");
    issue_op(32'h7FC00000, 32'h3F800000);
    issue_op(32'h3F800000, 32'hFFC00001);
    issue_op(32'h7F800001, 32'h3F800000);
    issue_op(32'hBF800000, 32'hFF800001);
    issue_op(32'h7F800000, 32'hFF800000);
    issue_op(32'h00000000, 32'h80000000);
    issue_op(32'hFF800000, 32'h40000000);
    issue_op(32'hC0400000, 32'h7F800000);
    issue_op(32'h3F800000, 32'h80000000);
    issue_op(32'h80000000, 32'hC0000000);
    end_test();

    begin_test("overflow_underflow");
    issue_op(32'h7F7FFFFF, 32'h00800000);
    issue_op(32'hFF000000, 32'h00800000);
    issue_op(32'h00800000, 32'h7F000000);
    issue_op(32'h80800000, 32'h4F000000);
    end_test();

    begin_test("subnormal_as_zero");
    issue_op(32'h00400000, 32'h3F800000);
    issue_op(32'h3F800000, 32'h80000001);
    end_test();

    repeat (4) @(posedge i_clk);
    $display("tests: %0d, operations: %0d, errors: %0d", n_tests, checked, errors);
    if (errors == 0 && checked == NUM_OPS) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog sized from the operation count
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// File: tb.f
+incdir+.
fdiv_pkg.sv
fdiv_unpack.sv
fdiv_mant_div.sv
fdiv_round.sv
fp_divider.sv
tb_fp_divider.sv

// File: run.sh
#!/bin/sh
# Compile the divider testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f \
  --top-module tb_fp_divider -o tb_fp_divider

out=$(./obj_dir/tb_fp_divider || true)
echo "$out"
echo "$out" | grep -q "^TEST PASS$"
